/* dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cpu side widths
`define DC_ADDR_W 32
`define DC_DATA_W 32

// cache geometry
`define DC_OFFSET_W 2       // word offset within a line
`define DC_INDEX_W 4        // 16 sets
`define DC_NUM_WAYS 4

// what is left of the word address once index and offset are taken
`define DC_TAG_W (`DC_ADDR_W - 2 - `DC_INDEX_W - `DC_OFFSET_W)
`define DC_LINE_W (`DC_DATA_W << `DC_OFFSET_W)

// write buffer, 8 entries
`define DC_WB_DEPTH_LOG2 3

`endif

/* dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;
    typedef logic [`DC_DATA_W-1:0] word_t;
    typedef logic [`DC_DATA_W/8-1:0] word_sel_t;
    typedef logic [`DC_LINE_W-1:0] line_t;
    typedef logic [`DC_LINE_W/8-1:0] line_sel_t;
    typedef logic [`DC_TAG_W+`DC_INDEX_W-1:0] line_addr_t;
    typedef logic [$clog2(`DC_NUM_WAYS)-1:0] way_idx_t;

    // word address, byte bits dropped
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_t;

    typedef struct packed {
        logic      we;
        addr_t     addr;
        word_sel_t sel;
        word_t     wdata;
    } cpu_req_t;

    // one line per transfer
    typedef struct packed {
        logic       we;
        line_addr_t addr;
        line_sel_t  sel;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        addr_t     addr;
        word_sel_t sel;
        word_t     wdata;
    } wb_entry_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, WAIT_DRAIN, WAIT_REFILL, INSTALL} ctrl_state_e;
    typedef enum logic [1:0] {MEM_IDLE, MEM_READ, MEM_WRITE} mem_state_e;

endpackage

/* tag_data_store.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module tag_data_store (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  re_i,
    input  dcache_pkg::index_t    index_i,
    input  dcache_pkg::tag_t      tag_i,
    input  logic                  we_i,
    input  logic                  install_i,
    input  dcache_pkg::way_idx_t  way_i,
    input  dcache_pkg::line_t     wline_i,
    input  dcache_pkg::line_sel_t wsel_i,
    output logic                  hit_o,
    output dcache_pkg::way_idx_t  hit_way_o,
    output dcache_pkg::line_t     hit_line_o
);

    localparam int unsigned NUM_SETS = 2 ** `DC_INDEX_W;
    localparam int unsigned NUM_WAYS = `DC_NUM_WAYS;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    dcache_pkg::tag_t    tag_mem [NUM_WAYS][NUM_SETS];
    dcache_pkg::line_t   line_mem [NUM_WAYS][NUM_SETS];

    // whole set read out, compared one cycle later
    logic [NUM_WAYS-1:0] rd_valid_q;
    dcache_pkg::tag_t    rd_tag_q [NUM_WAYS];
    dcache_pkg::line_t   rd_line_q [NUM_WAYS];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '{default: '0};
            rd_valid_q <= '0;
        end else begin
            if (re_i) begin
                rd_valid_q <= valid_q[index_i];
            end
            if (we_i && install_i) begin
                valid_q[index_i][way_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (re_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tag_q[w] <= tag_mem[w][index_i];
                rd_line_q[w] <= line_mem[w][index_i];
            end
        end
        if (we_i) begin
            if (install_i) begin
                tag_mem[way_i][index_i] <= tag_i;
            end
            for (int b = 0; b < `DC_LINE_W/8; b++) begin
                if (wsel_i[b]) begin    // all ones on install
                    line_mem[way_i][index_i][b*8 +: 8] <= wline_i[b*8 +: 8];
                end
            end
        end
    end

    // scan downwards so the lowest matching way wins
    always_comb begin
        hit_o = 1'b0;
        hit_way_o = '0;
        for (int w = NUM_WAYS-1; w >= 0; w--) begin
            if (rd_valid_q[w] && rd_tag_q[w] == tag_i) begin
                hit_o = 1'b1;
                hit_way_o = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit_line_o = rd_line_q[hit_way_o];

endmodule

/* plru_replace.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module plru_replace (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 update_i,
    input  dcache_pkg::index_t   index_i,
    input  dcache_pkg::way_idx_t access_way_i,
    output dcache_pkg::way_idx_t victim_way_o
);

    localparam int unsigned NUM_SETS = 2 ** `DC_INDEX_W;

    // [0] root, [1] picks between ways 0/1, [2] between ways 2/3
    logic [2:0] tree_q [NUM_SETS];
    logic [2:0] cur_bits;
    logic [2:0] next_bits;

    assign cur_bits = tree_q[index_i];
    assign victim_way_o = {cur_bits[0], cur_bits[0] ? cur_bits[2] : cur_bits[1]};

    // point every bit on the path away from the accessed way
    always_comb begin
        next_bits = cur_bits;
        next_bits[0] = ~access_way_i[1];
        if (access_way_i[1]) begin
            next_bits[2] = ~access_way_i[0];
        end else begin
            next_bits[1] = ~access_way_i[0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tree_q <= '{default: '0};
        end else if (update_i) begin
            tree_q[index_i] <= next_bits;
        end
    end

endmodule

/* cache_ctrl.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module cache_ctrl (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  cpu_stb_i,
    input  dcache_pkg::cpu_req_t  cpu_req_i,
    output logic                  cpu_ack_o,
    output dcache_pkg::word_t     cpu_rdata_o,
    output logic                  store_re_o,
    output dcache_pkg::index_t    store_index_o,
    output logic                  store_we_o,
    output logic                  store_install_o,
    output dcache_pkg::way_idx_t  store_way_o,
    output dcache_pkg::tag_t      store_tag_o,
    output dcache_pkg::line_t     store_wline_o,
    output dcache_pkg::line_sel_t store_wsel_o,
    input  logic                  hit_i,
    input  dcache_pkg::way_idx_t  hit_way_i,
    input  dcache_pkg::line_t     hit_line_i,
    output logic                  plru_update_o,
    output dcache_pkg::index_t    plru_index_o,
    output dcache_pkg::way_idx_t  plru_way_o,
    input  dcache_pkg::way_idx_t  victim_way_i,
    output logic                  wb_push_o,
    output dcache_pkg::wb_entry_t wb_entry_o,
    input  logic                  wb_full_i,
    input  logic                  wb_empty_i,
    output logic                  refill_req_o,
    output dcache_pkg::addr_t     refill_addr_o,
    input  logic                  refill_done_i,
    input  dcache_pkg::line_t     refill_line_i
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    dcache_pkg::cpu_req_t    req_q;
    logic                    in_idle;
    logic                    write_go;
    logic                    read_hit;
    logic                    install;
    dcache_pkg::way_idx_t    access_way;
    dcache_pkg::line_t       merge_line;
    dcache_pkg::line_sel_t   merge_sel;

    assign in_idle = state_q == dcache_pkg::IDLE;
    assign write_go = state_q == dcache_pkg::LOOKUP && req_q.we && !wb_full_i;
    assign read_hit = state_q == dcache_pkg::LOOKUP && !req_q.we && hit_i;
    assign install = state_q == dcache_pkg::INSTALL;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_idle && cpu_stb_i) begin
            req_q <= cpu_req_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (cpu_stb_i) state_d = dcache_pkg::LOOKUP;
            end
            dcache_pkg::LOOKUP: begin
                if (req_q.we) begin
                    if (!wb_full_i) state_d = dcache_pkg::IDLE;    // hit or miss, no allocate
                end else if (hit_i) begin
                    state_d = dcache_pkg::IDLE;
                end else begin
                    state_d = dcache_pkg::WAIT_DRAIN;
                end
            end
            // memory has to see every older store before the refill
            dcache_pkg::WAIT_DRAIN: begin
                if (wb_empty_i) state_d = dcache_pkg::WAIT_REFILL;
            end
            dcache_pkg::WAIT_REFILL: begin
                if (refill_done_i) state_d = dcache_pkg::INSTALL;
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    // word and byte selects moved to their slot in the line
    assign merge_line = dcache_pkg::line_t'(req_q.wdata) << (req_q.addr.offset * `DC_DATA_W);
    assign merge_sel = dcache_pkg::line_sel_t'(req_q.sel) << (req_q.addr.offset * (`DC_DATA_W/8));
    assign access_way = install ? victim_way_i : hit_way_i;

    assign store_re_o = in_idle && cpu_stb_i;
    assign store_index_o = in_idle ? cpu_req_i.addr.index : req_q.addr.index;
    assign store_we_o = (write_go && hit_i) || install;
    assign store_install_o = install;
    assign store_way_o = access_way;
    assign store_tag_o = req_q.addr.tag;     // compare tag as well
    assign store_wline_o = install ? refill_line_i : merge_line;
    assign store_wsel_o = install ? '1 : merge_sel;

    assign plru_update_o = (write_go && hit_i) || read_hit || install;
    assign plru_index_o = req_q.addr.index;
    assign plru_way_o = access_way;

    assign wb_push_o = write_go;
    assign wb_entry_o = '{addr: req_q.addr, sel: req_q.sel, wdata: req_q.wdata};

    assign refill_req_o = state_q == dcache_pkg::WAIT_REFILL;
    assign refill_addr_o = req_q.addr;

    // early restart, answer straight from the returned line
    assign cpu_ack_o = write_go || read_hit || install;
    assign cpu_rdata_o = install ? refill_line_i[req_q.addr.offset * `DC_DATA_W +: `DC_DATA_W]
                                 : hit_line_i[req_q.addr.offset * `DC_DATA_W +: `DC_DATA_W];

endmodule

/* write_buffer.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module write_buffer #(
    parameter int unsigned DEPTH_LOG2 = `DC_WB_DEPTH_LOG2
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  push_i,
    input  dcache_pkg::wb_entry_t entry_i,
    input  logic                  pop_i,
    output dcache_pkg::wb_entry_t head_o,
    output logic                  empty_o,
    output logic                  full_o
);

    dcache_pkg::wb_entry_t fifo_mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2:0]   wr_ptr_q;     // top bit is the wrap flag
    logic [DEPTH_LOG2:0]   rd_ptr_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            fifo_mem[wr_ptr_q[DEPTH_LOG2-1:0]] <= entry_i;
        end
    end

    assign head_o = fifo_mem[rd_ptr_q[DEPTH_LOG2-1:0]];
    assign empty_o = wr_ptr_q == rd_ptr_q;
    // same slot, different lap
    assign full_o = (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2])
                 && (wr_ptr_q[DEPTH_LOG2-1:0] == rd_ptr_q[DEPTH_LOG2-1:0]);

endmodule

/* mem_port.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module mem_port (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  refill_req_i,
    input  dcache_pkg::addr_t     refill_addr_i,
    output logic                  refill_done_o,
    output dcache_pkg::line_t     refill_line_o,
    input  logic                  wb_empty_i,
    input  dcache_pkg::wb_entry_t wb_head_i,
    output logic                  wb_pop_o,
    output logic                  mem_stb_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  logic                  mem_ack_i,
    input  dcache_pkg::line_t     mem_rdata_i
);

    dcache_pkg::mem_state_e state_q;
    logic                   stb_q;
    logic                   done_q;
    dcache_pkg::mem_req_t   req_q;
    dcache_pkg::line_t      line_q;
    logic                   refill_go;
    dcache_pkg::mem_req_t   read_req;
    dcache_pkg::mem_req_t   write_req;

    // request is still up during the done pulse, don't start it again
    assign refill_go = refill_req_i && !done_q;
    assign wb_pop_o = state_q == dcache_pkg::MEM_IDLE && !refill_go && !wb_empty_i;

    always_comb begin
        read_req = '0;
        read_req.addr = {refill_addr_i.tag, refill_addr_i.index};
        read_req.sel = '1;
        write_req.we = 1'b1;
        write_req.addr = {wb_head_i.addr.tag, wb_head_i.addr.index};
        write_req.sel = dcache_pkg::line_sel_t'(wb_head_i.sel)
                        << (wb_head_i.addr.offset * (`DC_DATA_W/8));
        write_req.wdata = dcache_pkg::line_t'(wb_head_i.wdata)
                          << (wb_head_i.addr.offset * `DC_DATA_W);
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= dcache_pkg::MEM_IDLE;
            stb_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                dcache_pkg::MEM_IDLE: begin
                    if (refill_go) begin        // refill ahead of drains
                        state_q <= dcache_pkg::MEM_READ;
                        stb_q <= 1'b1;
                    end else if (!wb_empty_i) begin
                        state_q <= dcache_pkg::MEM_WRITE;
                        stb_q <= 1'b1;
                    end
                end
                dcache_pkg::MEM_READ: begin
                    if (mem_ack_i) begin
                        state_q <= dcache_pkg::MEM_IDLE;
                        stb_q <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
                dcache_pkg::MEM_WRITE: begin
                    if (mem_ack_i) begin
                        state_q <= dcache_pkg::MEM_IDLE;
                        stb_q <= 1'b0;
                    end
                end
                default: state_q <= dcache_pkg::MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == dcache_pkg::MEM_IDLE) begin
            req_q <= refill_go ? read_req : write_req;   // held while stb is up
        end
        if (state_q == dcache_pkg::MEM_READ && mem_ack_i) begin
            line_q <= mem_rdata_i;
        end
    end

    assign mem_stb_o = stb_q;
    assign mem_req_o = req_q;
    assign refill_done_o = done_q;
    assign refill_line_o = line_q;

endmodule

/* dcache_top.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 cpu_stb_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output logic                 cpu_ack_o,
    output dcache_pkg::word_t    cpu_rdata_o,
    output logic                 mem_stb_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic                 mem_ack_i,
    input  dcache_pkg::line_t    mem_rdata_i
);

    logic                  store_re;
    logic                  store_we;
    logic                  store_install;
    dcache_pkg::index_t    store_index;
    dcache_pkg::way_idx_t  store_way;
    dcache_pkg::tag_t      store_tag;
    dcache_pkg::line_t     store_wline;
    dcache_pkg::line_sel_t store_wsel;
    logic                  hit;
    dcache_pkg::way_idx_t  hit_way;
    dcache_pkg::line_t     hit_line;
    logic                  plru_update;
    dcache_pkg::index_t    plru_index;
    dcache_pkg::way_idx_t  plru_way;
    dcache_pkg::way_idx_t  victim_way;
    logic                  wb_push;
    logic                  wb_pop;
    logic                  wb_full;
    logic                  wb_empty;
    dcache_pkg::wb_entry_t wb_entry;
    dcache_pkg::wb_entry_t wb_head;
    logic                  refill_req;
    logic                  refill_done;
    dcache_pkg::addr_t     refill_addr;
    dcache_pkg::line_t     refill_line;

    cache_ctrl ctrl_i (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .cpu_stb_i(cpu_stb_i), .cpu_req_i(cpu_req_i),
        .cpu_ack_o(cpu_ack_o), .cpu_rdata_o(cpu_rdata_o),
        .store_re_o(store_re), .store_index_o(store_index),
        .store_we_o(store_we), .store_install_o(store_install),
        .store_way_o(store_way), .store_tag_o(store_tag),
        .store_wline_o(store_wline), .store_wsel_o(store_wsel),
        .hit_i(hit), .hit_way_i(hit_way), .hit_line_i(hit_line),
        .plru_update_o(plru_update), .plru_index_o(plru_index),
        .plru_way_o(plru_way), .victim_way_i(victim_way),
        .wb_push_o(wb_push), .wb_entry_o(wb_entry),
        .wb_full_i(wb_full), .wb_empty_i(wb_empty),
        .refill_req_o(refill_req), .refill_addr_o(refill_addr),
        .refill_done_i(refill_done), .refill_line_i(refill_line)
    );

    tag_data_store store_i (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .re_i(store_re), .index_i(store_index), .tag_i(store_tag),
        .we_i(store_we), .install_i(store_install), .way_i(store_way),
        .wline_i(store_wline), .wsel_i(store_wsel),
        .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line)
    );

    plru_replace plru_i (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .update_i(plru_update), .index_i(plru_index),
        .access_way_i(plru_way), .victim_way_o(victim_way)
    );

    write_buffer #(.DEPTH_LOG2(`DC_WB_DEPTH_LOG2)) wbuf_i (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .push_i(wb_push), .entry_i(wb_entry),
        .pop_i(wb_pop), .head_o(wb_head),
        .empty_o(wb_empty), .full_o(wb_full)
    );

    mem_port mem_port_i (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .refill_req_i(refill_req), .refill_addr_i(refill_addr),
        .refill_done_o(refill_done), .refill_line_o(refill_line),
        .wb_empty_i(wb_empty), .wb_head_i(wb_head), .wb_pop_o(wb_pop),
        .mem_stb_o(mem_stb_o), .mem_req_o(mem_req_o),
        .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
    );

endmodule

/* dcache_checker.sv */
`timescale 1ns/100ps

module dcache_checker (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 cpu_stb_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    input  logic                 cpu_ack_i,
    input  dcache_pkg::word_t    cpu_rdata_i,
    input  logic                 mem_stb_i,
    input  dcache_pkg::mem_req_t mem_req_i,
    input  logic                 mem_ack_i,
    input  int                   test_i,
    input  logic                 mark_i,
    input  int                   exp_reads_i,     // -1 means no check
    input  int                   exp_lat_i,
    input  logic                 done_i,
    input  logic                 finish_i,
    output int                   err_cnt_o,
    output int                   pending_o      // acked cpu writes not yet in memory
);

    dcache_pkg::word_t    image [int unsigned];
    dcache_pkg::mem_req_t exp_q [$];
    logic                 seen_stb;
    int                   reads_seen;
    int                   wait_cnt;
    int                   last_lat;
    int                   test_errs;
    int                   tests_run;
    int                   tests_failed;
    int                   checks;

    function automatic dcache_pkg::word_t fill_word(input int unsigned a);
        return (a * 32'h9e3779b1) ^ {a[29:0], 2'b11};
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        err_cnt_o++;
        test_errs++;
    endtask

    always @(posedge clk_i) begin : monitor
        dcache_pkg::mem_req_t exp;
        dcache_pkg::word_t    cur;
        int unsigned          wa;
        logic                 bad;
        if (!rstn_i) begin
            seen_stb = 1'b0;
            reads_seen = 0;
            wait_cnt = 0;
            last_lat = 0;
            test_errs = 0;
            tests_run = 0;
            tests_failed = 0;
            checks = 0;
            err_cnt_o = 0;
            pending_o = 0;
            exp_q.delete();
        end else begin
            if (!seen_stb && !cpu_stb_i && (cpu_ack_i || mem_stb_i))
                report_error("bus activity before the first request");
            seen_stb = seen_stb || cpu_stb_i;
            if (cpu_stb_i && !cpu_ack_i) wait_cnt++;
            if (cpu_ack_i) begin
                last_lat = wait_cnt + 1;   // edges from capture to ack
                wait_cnt = 0;
                wa = 32'(cpu_req_i.addr);
                cur = image.exists(wa) ? image[wa] : fill_word(wa);
                if (cpu_req_i.we) begin
                    for (int b = 0; b < 4; b++)
                        if (cpu_req_i.sel[b]) cur[b*8 +: 8] = cpu_req_i.wdata[b*8 +: 8];
                    image[wa] = cur;
                    // only the addressed word of the line carries data and selects
                    exp = '0;
                    exp.we = 1'b1;
                    exp.addr = {cpu_req_i.addr.tag, cpu_req_i.addr.index};
                    for (int w = 0; w < 4; w++) begin
                        if (w == int'(cpu_req_i.addr.offset)) begin
                            exp.sel[w*4 +: 4] = cpu_req_i.sel;
                            exp.wdata[w*32 +: 32] = cpu_req_i.wdata;
                        end
                    end
                    exp_q.push_back(exp);
                    pending_o++;
                end else begin
                    checks++;
                    if (cpu_rdata_i !== cur)
                        report_error($sformatf("read of %h returned %h, expected %h",
                                               wa, cpu_rdata_i, cur));
                end
            end
            if (mem_stb_i && mem_ack_i) begin
                if (!mem_req_i.we) begin
                    reads_seen++;
                    checks++;
                    // a refill only serves the read the cpu is waiting on
                    if (!cpu_stb_i || cpu_req_i.we
                        || mem_req_i.addr !== {cpu_req_i.addr.tag, cpu_req_i.addr.index})
                        report_error($sformatf("memory read of line %h, expected line %h",
                                               mem_req_i.addr,
                                               {cpu_req_i.addr.tag, cpu_req_i.addr.index}));
                end else if (exp_q.size() == 0) begin
                    report_error("memory write seen with no CPU write waiting for it");
                end else begin
                    exp = exp_q.pop_front();
                    pending_o--;
                    checks++;
                    bad = mem_req_i.addr !== exp.addr || mem_req_i.sel !== exp.sel;
                    for (int b = 0; b < 16; b++) begin
                        if (exp.sel[b] && mem_req_i.wdata[b*8 +: 8] !== exp.wdata[b*8 +: 8])
                            bad = 1'b1;
                    end
                    if (bad)
                        report_error($sformatf(
                            "memory write %h sel %h data %h, expected %h sel %h data %h",
                            mem_req_i.addr, mem_req_i.sel, mem_req_i.wdata,
                            exp.addr, exp.sel, exp.wdata));
                end
            end
            if (pending_o > 9)
                report_error($sformatf("%0d writes outstanding, limit is 9", pending_o));
            if (mark_i) begin
                checks++;
                if (exp_reads_i >= 0 && reads_seen != exp_reads_i)
                    report_error($sformatf("%0d memory reads, expected %0d", reads_seen, exp_reads_i));
                if (exp_lat_i >= 0 && last_lat != exp_lat_i)
                    report_error($sformatf("ack after %0d cycles, expected %0d", last_lat, exp_lat_i));
                reads_seen = 0;
            end
            if (done_i) begin
                tests_run++;
                if (test_errs != 0) tests_failed++;
                $display("test %0d: %s, %0d errors", test_i,
                         test_errs == 0 ? "ok" : "failed", test_errs);
                test_errs = 0;
            end
            if (finish_i)
                $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                         tests_run, tests_failed, checks, err_cnt_o);
        end
    end

endmodule

/* tb_dcache.sv */
`timescale 1ns/100ps

module tb_dcache;

    // tests 2 to 6 in cpu transactions, used to size the watchdog
    localparam int NUM_TRANS = 2 + 16 + 10 + 12 + 2000;

    logic                  clk;
    logic                  rstn;
    logic                  cpu_stb;
    dcache_pkg::cpu_req_t  cpu_req;
    logic                  cpu_ack;
    dcache_pkg::word_t     cpu_rdata;
    logic                  mem_stb;
    dcache_pkg::mem_req_t  mem_req;
    logic                  mem_ack;
    dcache_pkg::line_t     mem_rdata;

    integer                seed;
    int                    ack_delay;        // 0 gives random 1 to 6 cycles
    dcache_pkg::word_t     mem_words [int unsigned];
    int                    test_num;
    logic                  mark;
    int                    exp_reads;
    int                    exp_lat;
    logic                  test_done;
    logic                  finish;
    int                    err_cnt;
    int                    pending;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    dcache_top dut_i (
        .clk_i(clk), .rstn_i(rstn),
        .cpu_stb_i(cpu_stb), .cpu_req_i(cpu_req),
        .cpu_ack_o(cpu_ack), .cpu_rdata_o(cpu_rdata),
        .mem_stb_o(mem_stb), .mem_req_o(mem_req),
        .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
    );

    dcache_checker chk_i (
        .clk_i(clk), .rstn_i(rstn),
        .cpu_stb_i(cpu_stb), .cpu_req_i(cpu_req),
        .cpu_ack_i(cpu_ack), .cpu_rdata_i(cpu_rdata),
        .mem_stb_i(mem_stb), .mem_req_i(mem_req), .mem_ack_i(mem_ack),
        .test_i(test_num), .mark_i(mark), .exp_reads_i(exp_reads), .exp_lat_i(exp_lat),
        .done_i(test_done), .finish_i(finish),
        .err_cnt_o(err_cnt), .pending_o(pending)
    );

    // initial memory contents, spread over the whole word address
    function automatic dcache_pkg::word_t fill_word(input int unsigned a);
        return (a * 32'h9e3779b1) ^ {a[29:0], 2'b11};
    endfunction

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input int tag_sel, input int idx, input int off);
        dcache_pkg::addr_t a;
        a.tag = dcache_pkg::tag_t'(32'h40 + tag_sel);
        a.index = dcache_pkg::index_t'(idx);
        a.offset = dcache_pkg::offset_t'(off);
        return a;
    endfunction

    // starts 2 ns after an edge, returns 2 ns after the edge that took the ack
    task automatic cpu_access(input logic we, input dcache_pkg::addr_t a,
                              input dcache_pkg::word_sel_t sel, input dcache_pkg::word_t wd);
        cpu_req = '{we: we, addr: a, sel: sel, wdata: wd};
        cpu_stb = 1'b1;
        do @(negedge clk); while (!cpu_ack);
        @(posedge clk);
        #2;
        cpu_stb = 1'b0;
    endtask

    task automatic check_point(input int reads, input int lat);
        exp_reads = reads;
        exp_lat = lat;
        mark = 1'b1;
        @(posedge clk);
        #2;
        mark = 1'b0;
    endtask

    task automatic end_test();
        test_done = 1'b1;
        @(posedge clk);
        #2;
        test_done = 1'b0;
    endtask

    task automatic wait_drained();
        do @(negedge clk); while (pending != 0);
        @(posedge clk);
        #2;
    endtask

    task automatic random_write(input int tag_sel, input int idx);
        cpu_access(1'b1, make_addr(tag_sel, idx, rand_below(4)), 4'($random(seed)), $random(seed));
    endtask

    // one line per access, answered after a few cycles
    initial begin : memory_model
        dcache_pkg::mem_req_t req;
        dcache_pkg::word_t    cur;
        int unsigned          wa;
        int                   wait_cycles;
        mem_ack = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (rstn && mem_stb) begin
                req = mem_req;
                wait_cycles = (ack_delay > 0) ? ack_delay : 1 + rand_below(6);
                repeat (wait_cycles - 1) @(posedge clk);
                #2;
                for (int w = 0; w < 4; w++) begin
                    wa = {2'b00, req.addr, 2'(w)};
                    cur = mem_words.exists(wa) ? mem_words[wa] : fill_word(wa);
                    for (int b = 0; b < 4; b++) begin
                        if (req.we && req.sel[w*4+b]) cur[b*8 +: 8] = req.wdata[w*32+b*8 +: 8];
                    end
                    mem_words[wa] = cur;
                    mem_rdata[w*32 +: 32] = cur;
                end
                mem_ack = 1'b1;
                @(posedge clk);
                #2;
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int reread [4];
        seed = 17654;
        ack_delay = 0;
        rstn = 1'b0;
        cpu_stb = 1'b0;
        cpu_req = '0;
        mark = 1'b0;
        test_done = 1'b0;
        finish = 1'b0;
        exp_reads = -1;
        exp_lat = -1;
        test_num = 1;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;

        repeat (6) @(posedge clk);   // quiet bus until the first request
        #2;
        end_test();

        test_num = 2;
        check_point(-1, -1);
        cpu_access(1'b0, make_addr(0, 7, 1), '0, '0);
        check_point(1, -1);
        cpu_access(1'b0, make_addr(0, 7, 1), '0, '0);
        check_point(0, 2);
        end_test();

        test_num = 3;
        for (int k = 0; k < 16; k++) random_write(k % 3, 7);
        wait_drained();
        end_test();

        // five lines A to E in set 12, then E B C D hit and A was evicted
        test_num = 4;
        reread = '{4, 1, 2, 3};
        check_point(-1, -1);
        for (int k = 0; k < 5; k++) begin
            cpu_access(1'b0, make_addr(10 + k, 12, 0), '0, '0);
            check_point(1, -1);
        end
        for (int k = 0; k < 4; k++) begin
            cpu_access(1'b0, make_addr(10 + reread[k], 12, 2), '0, '0);
            check_point(0, -1);
        end
        cpu_access(1'b0, make_addr(10, 12, 3), '0, '0);
        check_point(1, -1);
        end_test();

        test_num = 5;
        ack_delay = 40;
        for (int k = 0; k < 12; k++) random_write(k % 4, 3);
        wait_drained();
        ack_delay = 0;
        end_test();

        test_num = 6;
        for (int k = 0; k < 2000; k++) begin
            if (rand_below(2) == 1) begin
                random_write(rand_below(6), rand_below(2) == 1 ? 3 : 9);
            end else begin
                cpu_access(1'b0, make_addr(rand_below(6), rand_below(2) == 1 ? 3 : 9,
                                           rand_below(4)), '0, '0);
            end
        end
        wait_drained();
        end_test();

        finish = 1'b1;
        @(posedge clk);
        #2;
        finish = 1'b0;
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TRANS * 200 * 20);
        $display("watchdog: run did not finish within %0d cycles", NUM_TRANS * 200);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
dcache_pkg.sv
tag_data_store.sv
plru_replace.sv
cache_ctrl.sv
write_buffer.sv
mem_port.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_dcache
FILELIST  ?= filelist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
